// ==== bench/cart_loader_tb.sv ====
/* Table-driven testbench for cart_loader_top. Streams iNES images byte by byte,
   then checks flags, status and sampled cartridge memory through the read port. */
`timescale 1ns/1ps

module cart_loader_tb;

  localparam int n_rows      = 8;
  localparam int idle_cycles = 5;   // Idle cycles after each strobe
  localparam int row_slack   = 200; // Reset, completion and reads per row
  localparam int prg_page    = 1 << ines_pkg::prg_page_shift;
  localparam int chr_page    = 1 << ines_pkg::chr_page_shift;

  // One test row with bytes 8 to 15 zero except byte 12
  typedef struct packed {
    logic [31:0]             magic;
    logic [7:0]              prg_pages;
    logic [7:0]              chr_pages;
    logic [7:0]              byte6;
    logic [7:0]              byte7;
    logic [7:0]              byte12;
    logic                    inv;
    ines_pkg::mapper_flags_t exp_flags;
    logic                    exp_error;
  } row_t;

  logic                              clk = 1'b0;
  logic                              reset_nes;
  logic [7:0]                        in_data;
  logic                              in_strobe;
  logic                              invert_mirroring;
  logic [cart_mem_pkg::addr_bits-1:0] rd_addr;
  ines_pkg::mapper_flags_t           flags;
  logic                              done;
  logic                              error;
  logic [7:0]                        rd_data;

  row_t  rows  [n_rows];
  string names [n_rows];

  cart_loader_top u_dut (
    .clk              (clk),
    .reset_nes        (reset_nes),
    .in_data          (in_data),
    .in_strobe        (in_strobe),
    .invert_mirroring (invert_mirroring),
    .rd_addr          (rd_addr),
    .flags            (flags),
    .done             (done),
    .error            (error),
    .rd_data          (rd_data)
  );

  always #50 clk = ~clk;

  function automatic ines_pkg::mapper_flags_t make_flags(input logic four, input logic ram,
      input logic mirr, input logic [2:0] chr_sz, input logic [2:0] prg_sz,
      input logic [7:0] mapper);
    ines_pkg::mapper_flags_t f;
    f             = '0;
    f.four_screen = four;
    f.chr_ram     = ram;
    f.mirroring   = mirr;
    f.chr_size    = chr_sz;
    f.prg_size    = prg_sz;
    f.mapper      = mapper;
    return f;
  endfunction

  function automatic logic [7:0] header_byte(input row_t r, input int k);
    case (k)
      0, 1, 2, 3: return r.magic[31 - 8*k -: 8]; // First magic byte sits in the top bits
      4:          return r.prg_pages;
      5:          return r.chr_pages;
      6:          return r.byte6;
      7:          return r.byte7;
      12:         return r.byte12;
      default:    return 8'h00;
    endcase
  endfunction

  // Failed images get no payload
  function automatic int payload_bytes(input row_t r);
    if (r.exp_error)
      return 0;
    return r.prg_pages * prg_page + r.chr_pages * chr_page;
  endfunction

  function automatic logic [7:0] pattern(input int i, input int row);
    return 8'(i * 7 + row);
  endfunction

  task automatic set_row(input int idx, input string name, input logic [31:0] magic,
      input logic [7:0] prg, input logic [7:0] chr, input logic [7:0] b6,
      input logic [7:0] b7, input logic [7:0] b12, input logic inv,
      input ines_pkg::mapper_flags_t f, input logic err);
    names[idx] = name;
    rows[idx]  = '{magic, prg, chr, b6, b7, b12, inv, f, err};
  endtask

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input string what,
      input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERROR %s %s: expected %h, actual %h", name, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    reset_nes <= 1'b1;
    repeat (8) @(posedge clk);
    reset_nes <= 1'b0;
  endtask

  task automatic send_byte(input logic [7:0] b);
    @(posedge clk);
    in_data   <= b;
    in_strobe <= 1'b1;
    @(posedge clk);
    in_strobe <= 1'b0;
    repeat (idle_cycles - 1) @(posedge clk);
  endtask

  task automatic wait_done(input string name);
    int n;
    n = 0;
    @(negedge clk);
    while (!done && n < 20) begin
      @(negedge clk);
      n++;
    end
    assert (done) else begin
      $display("Test %s: done never rose after the last byte", name);
      abort_run();
    end
  endtask

  // Registered read sampled mid-cycle
  task automatic read_check(input string name, input logic [21:0] addr,
      input logic [7:0] expected);
    @(posedge clk);
    rd_addr <= addr;
    @(posedge clk);
    @(negedge clk);
    check_value(name, $sformatf("read at %h", addr), expected, rd_data);
  endtask

  // Watchdog sized from the streamed bytes of every row
  initial begin
    longint limit;
    #1;
    limit = 0;
    for (int r = 0; r < n_rows; r++)
      limit += (ines_pkg::header_bytes + payload_bytes(rows[r])) * 6 + row_slack;
    #(limit * 100);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    abort_run();
  end

  initial begin
    int   total;
    int   prg_bytes;
    int   chr_bytes;
    int   offs [3];
    int   last;

    reset_nes        = 1'b1;
    in_data          = 8'h00;
    in_strobe        = 1'b0;
    invert_mirroring = 1'b0;
    rd_addr          = '0;

    set_row(0, "valid_2prg_1chr", 32'h4E45531A, 8'd2, 8'd1, 8'h31, 8'h40, 8'h00, 1'b0,
            make_flags(0, 0, 1, 3'd0, 3'd1, 8'h43), 1'b0);
    set_row(1, "bad_magic", 32'h4E45541A, 8'd2, 8'd1, 8'h31, 8'h40, 8'h00, 1'b0, '0, 1'b1);
    set_row(2, "trainer", 32'h4E45531A, 8'd2, 8'd1, 8'h34, 8'h40, 8'h00, 1'b0, '0, 1'b1);
    set_row(3, "dirty_header", 32'h4E45531A, 8'd0, 8'd0, 8'h20, 8'hA0, 8'h55, 1'b0,
            make_flags(0, 1, 0, 3'd0, 3'd0, 8'h02), 1'b0);
    set_row(4, "nes20_header", 32'h4E45531A, 8'd0, 8'd0, 8'h20, 8'hA8, 8'h55, 1'b0,
            make_flags(0, 1, 0, 3'd0, 3'd0, 8'hA2), 1'b0);
    set_row(5, "clean_header", 32'h4E45531A, 8'd0, 8'd0, 8'h20, 8'hA0, 8'h00, 1'b0,
            make_flags(0, 1, 0, 3'd0, 3'd0, 8'hA2), 1'b0);
    set_row(6, "four_screen_inv", 32'h4E45531A, 8'd0, 8'd0, 8'h09, 8'h00, 8'h00, 1'b1,
            make_flags(1, 1, 0, 3'd0, 3'd0, 8'h00), 1'b0);
    set_row(7, "invert_only", 32'h4E45531A, 8'd0, 8'd0, 8'h10, 8'h00, 8'h00, 1'b1,
            make_flags(0, 1, 1, 3'd0, 3'd0, 8'h01), 1'b0);

    for (int r = 0; r < n_rows; r++) begin
      pulse_reset();
      invert_mirroring <= rows[r].inv;
      @(negedge clk); // Status and flags start cleared
      check_value(names[r], "done after reset", 32'h0, 32'(done));
      check_value(names[r], "error after reset", 32'h0, 32'(error));
      check_value(names[r], "flags after reset", 32'h0, flags);
      for (int k = 0; k < ines_pkg::header_bytes; k++)
        send_byte(header_byte(rows[r], k));
      total = payload_bytes(rows[r]);
      for (int i = 0; i < total; i++)
        send_byte(pattern(i, r));

      wait_done(names[r]);
      check_value(names[r], "error", 32'(rows[r].exp_error), 32'(error));
      check_value(names[r], "flags", rows[r].exp_flags, flags);
      repeat (8) @(posedge clk); // Last slot write has landed by now

      prg_bytes = rows[r].exp_error ? 0 : rows[r].prg_pages * prg_page;
      chr_bytes = rows[r].exp_error ? 0 : rows[r].chr_pages * chr_page;
      if (prg_bytes != 0) begin
        last = (prg_bytes > cart_mem_pkg::prg_window_bytes) ?
               cart_mem_pkg::prg_window_bytes - 1 : prg_bytes - 1;
        offs = '{0, last / 2 + 1, last};
        foreach (offs[j])
          read_check(names[r], cart_mem_pkg::prg_base + 22'(offs[j]), pattern(offs[j], r));
      end
      if (chr_bytes != 0) begin
        last = (chr_bytes > cart_mem_pkg::chr_window_bytes) ?
               cart_mem_pkg::chr_window_bytes - 1 : chr_bytes - 1;
        offs = '{0, last / 2 + 1, last};
        foreach (offs[j])   // CHR payload follows the whole PRG payload
          read_check(names[r], cart_mem_pkg::chr_base + 22'(offs[j]),
                     pattern(prg_bytes + offs[j], r));
      end
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== files.f ====
source/ines_pkg.sv
source/cart_mem_pkg.sv
source/ines_loader.sv
source/slot_write_holder.sv
source/cart_store.sv
source/cart_loader_top.sv
bench/cart_loader_tb.sv

// ==== source/cart_loader_top.sv ====
/* Cartridge loading path: iNES parser, slot-timed write holder and the
   cartridge store, with a read port for inspecting loaded contents. */
`timescale 1ns/1ps

module cart_loader_top (
  input  logic                                clk,
  input  logic                                reset_nes,
  input  logic [7:0]                          in_data,
  input  logic                                in_strobe,
  input  logic                                invert_mirroring,
  input  logic [cart_mem_pkg::addr_bits-1:0]  rd_addr,
  output ines_pkg::mapper_flags_t             flags,
  output logic                                done,
  output logic                                error,
  output logic [7:0]                          rd_data
);

  cart_mem_pkg::mem_write_t load_wr;  // Loader to holder
  cart_mem_pkg::mem_write_t store_wr; // Holder to store, slot aligned

  ines_loader u_loader (
    .clk              (clk),
    .reset_nes        (reset_nes),
    .in_data          (in_data),
    .in_strobe        (in_strobe),
    .invert_mirroring (invert_mirroring),
    .load_wr          (load_wr),
    .flags            (flags),
    .done             (done),
    .error            (error)
  );

  slot_write_holder u_holder (
    .clk       (clk),
    .reset_nes (reset_nes),
    .load_wr   (load_wr),
    .store_wr  (store_wr)
  );

  cart_store u_store (
    .clk      (clk),
    .store_wr (store_wr),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

// ==== source/cart_mem_pkg.sv ====
/* Cartridge memory map, window sizes, slot period and the write request word.
   Shared by the loader, the slot holder and the store. */
package cart_mem_pkg;

  // Console memory address width
  localparam int addr_bits = 22;

  // Region bases, bit 21 picks CHR
  localparam logic [addr_bits-1:0] prg_base = 22'h00_0000;
  localparam logic [addr_bits-1:0] chr_base = 22'h20_0000;

  // Simulation-sized windows
  localparam int prg_window_bytes = 32768;
  localparam int chr_window_bytes = 8192;

  // Memory is granted one slot every four clocks
  localparam int slot_period = 4;

  // One byte write toward cartridge memory
  typedef struct packed {
    logic                 valid;
    logic [addr_bits-1:0] addr;
    logic [7:0]           data;
  } mem_write_t;

endpackage

// ==== source/cart_store.sv ====
/* Cartridge byte memory with PRG and CHR windows and a registered read port.
   Writes and reads outside a window are dropped or return zero. */
`timescale 1ns/1ps

module cart_store (
  input  logic                                clk,
  input  cart_mem_pkg::mem_write_t            store_wr,
  input  logic [cart_mem_pkg::addr_bits-1:0]  rd_addr,
  output logic [7:0]                          rd_data
);

  localparam int aw     = cart_mem_pkg::addr_bits;
  localparam int prg_aw = $clog2(cart_mem_pkg::prg_window_bytes);
  localparam int chr_aw = $clog2(cart_mem_pkg::chr_window_bytes);

  logic [7:0] prg_mem [cart_mem_pkg::prg_window_bytes];
  logic [7:0] chr_mem [cart_mem_pkg::chr_window_bytes];

  logic wr_prg;
  logic wr_chr;
  logic rd_prg;
  logic rd_chr;

  // Top bit selects the region, the rest is the offset in it
  function automatic logic in_prg(input logic [aw-1:0] a);
    return !a[aw-1] && (a[aw-2:0] < cart_mem_pkg::prg_window_bytes);
  endfunction

  function automatic logic in_chr(input logic [aw-1:0] a);
    return a[aw-1] && (a[aw-2:0] < cart_mem_pkg::chr_window_bytes);
  endfunction

  assign wr_prg = store_wr.valid && in_prg(store_wr.addr);
  assign wr_chr = store_wr.valid && in_chr(store_wr.addr);
  assign rd_prg = in_prg(rd_addr);
  assign rd_chr = in_chr(rd_addr);

  always_ff @(posedge clk) begin
    if (wr_prg)
      prg_mem[store_wr.addr[prg_aw-1:0]] <= store_wr.data;
    if (wr_chr)
      chr_mem[store_wr.addr[chr_aw-1:0]] <= store_wr.data;
  end

  always_ff @(posedge clk) begin
    if (rd_prg)
      rd_data <= prg_mem[rd_addr[prg_aw-1:0]];
    else if (rd_chr)
      rd_data <= chr_mem[rd_addr[chr_aw-1:0]];
    else
      rd_data <= 8'h00; // Unmapped
  end

endmodule

// ==== source/ines_loader.sv ====
/* Parses an iNES byte stream, decodes the mapper flags and turns each payload
   byte into a write request, PRG region first and CHR region after. */
`timescale 1ns/1ps

module ines_loader (
  input  logic                       clk,
  input  logic                       reset_nes,
  input  logic [7:0]                 in_data,
  input  logic                       in_strobe,
  input  logic                       invert_mirroring,
  output cart_mem_pkg::mem_write_t   load_wr,
  output ines_pkg::mapper_flags_t    flags,
  output logic                       done,
  output logic                       error
);

  localparam int aw       = cart_mem_pkg::addr_bits;
  localparam int ctr_bits = $clog2(ines_pkg::header_bytes);
  localparam logic [ctr_bits-1:0] last_hdr = ctr_bits'(ines_pkg::header_bytes - 1);

  typedef enum logic [1:0] {
    st_header,
    st_prg,
    st_chr,
    st_failed
  } state_t;

  state_t                  state;
  logic [ctr_bits-1:0]     ctr;
  logic [7:0]              header [ines_pkg::header_bytes];
  logic [aw-1:0]           bytes_left;
  logic [aw-1:0]           wr_addr;
  logic                    tail_nonzero;
  logic                    is_nes20;
  logic                    is_dirty;
  logic                    image_ok;
  ines_pkg::mapper_flags_t next_flags;

  // Smallest k with pages <= 2**k, saturating at 7
  function automatic logic [2:0] size_code(input logic [7:0] pages);
    logic [2:0] code;
    code = 3'd7;
    for (int k = 6; k >= 0; k--) begin
      if (pages <= (9'd1 << k))
        code = 3'(k);
    end
    return code;
  endfunction

  // Header bytes, written only while parsing
  always_ff @(posedge clk) begin
    if (state == st_header && in_strobe)
      header[ctr] <= in_data;
  end

  // Bytes 8 to 15 should be zero on a clean iNES 1.0 header
  always_comb begin
    tail_nonzero = 1'b0;
    for (int i = 8; i < ines_pkg::header_bytes; i++) begin
      tail_nonzero = tail_nonzero | (header[i] != 8'h00);
    end
  end

  assign is_nes20 = (header[7][3:2] == 2'b10);
  assign is_dirty = !is_nes20 && tail_nonzero;

  // Magic word present and no trainer
  assign image_ok = (header[0] == ines_pkg::magic_0) &&
                    (header[1] == ines_pkg::magic_1) &&
                    (header[2] == ines_pkg::magic_2) &&
                    (header[3] == ines_pkg::magic_3) &&
                    !header[6][2];

  always_comb begin
    next_flags             = '0;
    next_flags.four_screen = header[6][3];
    next_flags.chr_ram     = (header[5] == 8'h00);
    next_flags.mirroring   = header[6][0] ^ invert_mirroring;
    next_flags.chr_size    = size_code(header[5]);
    next_flags.prg_size    = size_code(header[4]);
    next_flags.mapper      = {is_dirty ? 4'h0 : header[7][7:4], header[6][7:4]};
  end

  // Payload bytes pass straight through as requests
  assign load_wr.valid = in_strobe && (bytes_left != '0) &&
                         (state == st_prg || state == st_chr);
  assign load_wr.addr  = wr_addr;
  assign load_wr.data  = in_data;

  always_ff @(posedge clk) begin
    if (reset_nes) begin
      state      <= st_header;
      ctr        <= '0;
      bytes_left <= '0;
      wr_addr    <= cart_mem_pkg::prg_base;
      flags      <= '0;
      done       <= 1'b0;
      error      <= 1'b0;
    end else begin
      case (state)
        st_header: begin
          if (in_strobe) begin
            ctr <= ctr + 1'b1;
            if (ctr == last_hdr) begin
              bytes_left <= aw'(header[4]) << ines_pkg::prg_page_shift;
              if (image_ok) begin
                state <= st_prg;
              end else begin
                state <= st_failed; // Flags stay zero
                done  <= 1'b1;
                error <= 1'b1;
              end
            end
          end
        end
        st_prg: begin
          if (bytes_left != '0) begin
            if (in_strobe) begin
              bytes_left <= bytes_left - 1'b1;
              wr_addr    <= wr_addr + 1'b1;
            end
          end else begin
            state      <= st_chr;
            wr_addr    <= cart_mem_pkg::chr_base;
            bytes_left <= aw'(header[5]) << ines_pkg::chr_page_shift;
          end
        end
        st_chr: begin
          if (bytes_left != '0) begin
            if (in_strobe) begin
              bytes_left <= bytes_left - 1'b1;
              wr_addr    <= wr_addr + 1'b1;
            end
          end else if (!done) begin
            done  <= 1'b1;
            flags <= next_flags;
          end
        end
        default: begin // st_failed, held until reset
          done  <= 1'b1;
          error <= 1'b1;
        end
      endcase
    end
  end

endmodule

// ==== source/ines_pkg.sv ====
/* iNES header layout, magic word and the decoded mapper flags word.
   Shared by the loader, the top and the testbench. */
package ines_pkg;

  // Fixed header length ahead of the payload
  localparam int header_bytes = 16;

  // "NES" followed by MS-DOS end of file
  localparam logic [7:0] magic_0 = 8'h4E;
  localparam logic [7:0] magic_1 = 8'h45;
  localparam logic [7:0] magic_2 = 8'h53;
  localparam logic [7:0] magic_3 = 8'h1A;

  // Page sizes as shift amounts
  localparam int prg_page_shift = 14; // 16 KiB per PRG page
  localparam int chr_page_shift = 13; // 8 KiB per CHR page

  // Cartridge description handed to the console once loading ends.
  // The size codes are log2 of the page count, rounded up and capped at 7.
  typedef struct packed {
    logic [14:0] reserved;    // Always zero
    logic        four_screen; // Byte 6 bit 3
    logic        chr_ram;     // No CHR pages in the image
    logic        mirroring;   // Byte 6 bit 0, possibly inverted
    logic [2:0]  chr_size;
    logic [2:0]  prg_size;
    logic [7:0]  mapper;      // Upper nibble from byte 7, lower from byte 6
  } mapper_flags_t;

endpackage

// ==== source/slot_write_holder.sv ====
/* Holds one write request and issues it on the next memory slot.
   A newer request overwrites one still waiting. */
`timescale 1ns/1ps

module slot_write_holder (
  input  logic                     clk,
  input  logic                     reset_nes,
  input  cart_mem_pkg::mem_write_t load_wr,
  output cart_mem_pkg::mem_write_t store_wr
);

  localparam int phase_bits = $clog2(cart_mem_pkg::slot_period);
  localparam logic [phase_bits-1:0] last_phase = phase_bits'(cart_mem_pkg::slot_period - 1);

  logic [phase_bits-1:0]    phase;
  logic                     slot_last;
  logic                     pending;
  cart_mem_pkg::mem_write_t req;

  assign slot_last = (phase == last_phase);

  // Free-running slot counter
  always_ff @(posedge clk) begin
    if (reset_nes)
      phase <= '0;
    else if (slot_last)
      phase <= '0;
    else
      phase <= phase + 1'b1;
  end

  // New request wins over a release in the same cycle
  always_ff @(posedge clk) begin
    if (reset_nes) begin
      pending <= 1'b0;
    end else begin
      if (slot_last)
        pending <= 1'b0;
      if (load_wr.valid)
        pending <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_wr.valid)
      req <= load_wr;
  end

  assign store_wr.valid = pending && slot_last;
  assign store_wr.addr  = req.addr;
  assign store_wr.data  = req.data;

endmodule
